/* src/lock_macros.svh */
`ifndef LOCK_MACROS_SVH
`define LOCK_MACROS_SVH

// keypad line positions of the control keys
`define KEY_ENTER_BIT        4'd0
`define KEY_CLEAR_ALL_BIT    4'd8
`define KEY_CLEAR_ENTRY_BIT  4'd12

// display words
`define DISPLAY_BLANK        12'hFFF
`define DISPLAY_PASS         12'hBCC   // "ASS"
`define DISPLAY_LOCKED       12'h000

`define MAX_TRIES            3'd6
`define CODE_RESET           12'h246

// tone timing in clock cycles, scaled down for simulation
`define CLICK_HALF           4'd4
`define CLICK_LEN            7'd40
`define SUCCESS_HALF         4'd2
`define SUCCESS_LEN          7'd120
`define FAIL_HALF            4'd8
`define FAIL_LEN             7'd100
`define FAIL_GAP             7'd60

// register map
`define REG_CODE             4'h0
`define REG_STATUS           4'h4
`define REG_CONTROL          4'h8

`endif

/* src/lock_pkg.sv */
package lock_pkg;

    typedef logic [3:0]  digit_t;      // one bcd digit
    typedef logic [11:0] code_t;       // three digits, newest in low nibble
    typedef logic [2:0]  try_count_t;
    typedef logic [3:0]  axi_addr_t;
    typedef logic [31:0] axi_data_t;

    typedef enum logic [1:0] {
        KEY_DIGIT,
        KEY_ENTER,
        KEY_CLEAR_ENTRY,
        KEY_CLEAR_ALL
    } key_kind_e;

    typedef struct packed {
        logic      valid;
        key_kind_e kind;
        digit_t    digit;
    } key_event_t;

    // ordered by priority, higher value wins
    typedef enum logic [1:0] {
        TONE_NONE,
        TONE_CLICK,
        TONE_SUCCESS,
        TONE_FAIL
    } tone_e;

    typedef enum logic [1:0] {
        ST_ENTRY,
        ST_OPEN,
        ST_LOCKED
    } lock_state_e;

    typedef struct packed {
        lock_state_e state;
        try_count_t  tries;
    } lock_status_t;

    typedef struct packed {
        logic      awvalid;
        axi_addr_t awaddr;
        logic      wvalid;
        axi_data_t wdata;
        logic [3:0] wstrb;
        logic      bready;
        logic      arvalid;
        axi_addr_t araddr;
        logic      rready;
    } axil_req_t;

    typedef struct packed {
        logic       awready;
        logic       wready;
        logic       bvalid;
        logic [1:0] bresp;
        logic       arready;
        logic       rvalid;
        axi_data_t  rdata;
        logic [1:0] rresp;
    } axil_rsp_t;

endpackage

/* src/keypad_decoder.sv */
`timescale 1ns/1ps
`include "lock_macros.svh"

module keypad_decoder (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [15:0]           onehot,
    output lock_pkg::key_event_t  key_event
);
    import lock_pkg::*;

    logic [15:0] onehot_q;    // last sampled lines
    logic [3:0]  key_idx;
    key_event_t  next_event;

    always_comb begin
        key_idx = '0;
        for (int i = 0; i < 16; i++) begin
            if (onehot[i]) key_idx = 4'(i);
        end

        next_event       = '0;    // kind defaults to KEY_DIGIT
        next_event.valid = $onehot(onehot) && (onehot != onehot_q);
        case (key_idx)
            `KEY_ENTER_BIT:       next_event.kind = KEY_ENTER;
            `KEY_CLEAR_ALL_BIT:   next_event.kind = KEY_CLEAR_ALL;
            `KEY_CLEAR_ENTRY_BIT: next_event.kind = KEY_CLEAR_ENTRY;
            4'd3:  next_event.digit = 4'd0;
            4'd7:  next_event.digit = 4'd1;
            4'd6:  next_event.digit = 4'd2;
            4'd5:  next_event.digit = 4'd3;
            4'd11: next_event.digit = 4'd4;
            4'd10: next_event.digit = 4'd5;
            4'd9:  next_event.digit = 4'd6;
            4'd15: next_event.digit = 4'd7;
            4'd14: next_event.digit = 4'd8;
            4'd13: next_event.digit = 4'd9;
            default: next_event.valid = 1'b0;    // lines 1, 2, 4 unused
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            onehot_q  <= '0;
            key_event <= '0;
        end else begin
            onehot_q  <= onehot;
            key_event <= next_event;    // one-cycle pulse per new press
        end
    end

endmodule

/* src/code_checker.sv */
`timescale 1ns/1ps
`include "lock_macros.svh"

module code_checker (
    input  logic                   clk,
    input  logic                   reset,
    input  lock_pkg::key_event_t   key_event,
    input  lock_pkg::code_t        stored_code,
    input  logic                   unlock,
    output lock_pkg::code_t        display,
    output lock_pkg::lock_status_t status,
    output lock_pkg::tone_e        tone_req
);
    import lock_pkg::*;

    lock_state_e state_q;
    try_count_t  tries_q;
    try_count_t  tries_next;
    code_t       display_q;
    logic [1:0]  digit_cnt;    // digits held in the entry

    assign tries_next = tries_q + 3'd1;

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q   <= ST_ENTRY;
            tries_q   <= '0;
            display_q <= `DISPLAY_BLANK;
            digit_cnt <= '0;
            tone_req  <= TONE_NONE;
        end else begin
            tone_req <= TONE_NONE;    // request lasts one cycle
            if (unlock) begin
                state_q   <= ST_ENTRY;
                tries_q   <= '0;
                display_q <= `DISPLAY_BLANK;
                digit_cnt <= '0;
            end else if (key_event.valid) begin
                case (key_event.kind)
                    KEY_DIGIT: begin
                        if (state_q == ST_ENTRY && digit_cnt != 2'd3) begin
                            display_q <= {display_q[7:0], key_event.digit};
                            digit_cnt <= digit_cnt + 2'd1;
                            tone_req  <= TONE_CLICK;
                        end
                    end
                    KEY_ENTER: begin
                        if (state_q == ST_ENTRY && digit_cnt == 2'd3) begin
                            if (display_q == stored_code) begin
                                display_q <= `DISPLAY_PASS;
                                state_q   <= ST_OPEN;
                                tone_req  <= TONE_SUCCESS;
                            end else begin
                                display_q <= `DISPLAY_BLANK;
                                digit_cnt <= '0;
                                tries_q   <= tries_next;
                                tone_req  <= TONE_FAIL;
                                if (tries_next == `MAX_TRIES) begin
                                    state_q   <= ST_LOCKED;
                                    display_q <= `DISPLAY_LOCKED;
                                end
                            end
                        end
                    end
                    KEY_CLEAR_ENTRY: begin
                        if (state_q != ST_LOCKED) begin    // lockout keeps zeros
                            display_q <= `DISPLAY_BLANK;
                            digit_cnt <= '0;
                            state_q   <= ST_ENTRY;
                        end
                    end
                    KEY_CLEAR_ALL: begin
                        display_q <= `DISPLAY_BLANK;
                        digit_cnt <= '0;
                        tries_q   <= '0;
                        state_q   <= ST_ENTRY;
                    end
                    default: ;
                endcase
            end
        end
    end

    assign display      = display_q;
    assign status.state = state_q;
    assign status.tries = tries_q;

endmodule

/* src/buzzer_tone.sv */
`timescale 1ns/1ps
`include "lock_macros.svh"

module buzzer_tone (
    input  logic            clk,
    input  logic            reset,
    input  lock_pkg::tone_e tone_req,
    output logic            buzzer
);
    import lock_pkg::*;

    tone_e      active;
    logic [6:0] dur_cnt;     // cycles since pattern start
    logic [3:0] half_cnt;    // cycles in current half period
    logic [6:0] len_sel;
    logic [3:0] half_sel;
    logic       accept;

    always_comb begin
        case (active)
            TONE_SUCCESS: begin
                len_sel  = `SUCCESS_LEN;
                half_sel = `SUCCESS_HALF;
            end
            TONE_FAIL: begin
                len_sel  = `FAIL_LEN;
                half_sel = `FAIL_HALF;
            end
            default: begin
                len_sel  = `CLICK_LEN;
                half_sel = `CLICK_HALF;
            end
        endcase
    end

    // equal or higher priority restarts the pattern
    assign accept = (tone_req != TONE_NONE) && (tone_req >= active);

    always_ff @(posedge clk) begin
        if (reset) begin
            active   <= TONE_NONE;
            dur_cnt  <= '0;
            half_cnt <= '0;
            buzzer   <= 1'b0;
        end else if (accept) begin
            active   <= tone_req;
            dur_cnt  <= '0;
            half_cnt <= '0;
            buzzer   <= 1'b1;    // every pattern starts high
        end else if (active != TONE_NONE) begin
            dur_cnt  <= dur_cnt + 7'd1;
            half_cnt <= half_cnt + 4'd1;
            if (half_cnt == half_sel - 4'd1) begin
                buzzer   <= ~buzzer;
                half_cnt <= '0;
            end
            if (active == TONE_FAIL && dur_cnt >= `FAIL_GAP) begin
                buzzer <= 1'b0;    // silent tail of the fail pattern
            end
            if (dur_cnt == len_sel - 7'd1) begin
                active <= TONE_NONE;
                buzzer <= 1'b0;
            end
        end
    end

endmodule

/* src/lock_regs.sv */
`timescale 1ns/1ps
`include "lock_macros.svh"

module lock_regs (
    input  logic                   clk,
    input  logic                   reset,
    input  lock_pkg::axil_req_t    axil_req,
    output lock_pkg::axil_rsp_t    axil_rsp,
    input  lock_pkg::lock_status_t status,
    output lock_pkg::code_t        stored_code,
    output logic                   unlock
);
    import lock_pkg::*;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    logic       aw_w_ready;    // awready and wready move together
    logic       bvalid_q;
    logic [1:0] bresp_q;
    logic       arready_q;
    logic       rvalid_q;
    axi_data_t  rdata_q;
    logic [1:0] rresp_q;
    code_t      code_q;
    axi_data_t  rd_data;
    logic [1:0] rd_resp;
    logic       wr_fire;
    logic       rd_fire;

    assign wr_fire = aw_w_ready && axil_req.awvalid && axil_req.wvalid;
    assign rd_fire = arready_q && axil_req.arvalid;

    always_comb begin
        rd_data = '0;
        rd_resp = RESP_OKAY;
        case (axil_req.araddr)
            `REG_CODE:    rd_data = {20'd0, code_q};
            `REG_STATUS:  rd_data = {27'd0, status.tries, status.state};
            `REG_CONTROL: rd_data = '0;
            default:      rd_resp = RESP_SLVERR;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            aw_w_ready <= 1'b0;
            bvalid_q   <= 1'b0;
            bresp_q    <= RESP_OKAY;
            arready_q  <= 1'b0;
            rvalid_q   <= 1'b0;
            rdata_q    <= '0;
            rresp_q    <= RESP_OKAY;
            code_q     <= `CODE_RESET;
            unlock     <= 1'b0;
        end else begin
            unlock <= 1'b0;

            // write channel
            if (wr_fire) begin
                aw_w_ready <= 1'b0;
                bvalid_q   <= 1'b1;
                bresp_q    <= RESP_OKAY;
                case (axil_req.awaddr)
                    `REG_CODE: begin
                        if (axil_req.wstrb[0]) code_q[7:0]  <= axil_req.wdata[7:0];
                        if (axil_req.wstrb[1]) code_q[11:8] <= axil_req.wdata[11:8];
                    end
                    `REG_STATUS: ;    // read only
                    `REG_CONTROL: unlock <= axil_req.wstrb[0] && axil_req.wdata[0];
                    default: bresp_q <= RESP_SLVERR;
                endcase
            end else if (axil_req.awvalid && axil_req.wvalid && !aw_w_ready && !bvalid_q) begin
                aw_w_ready <= 1'b1;
            end else begin
                aw_w_ready <= 1'b0;
            end
            if (bvalid_q && axil_req.bready) bvalid_q <= 1'b0;

            // read channel
            if (rd_fire) begin
                arready_q <= 1'b0;
                rvalid_q  <= 1'b1;
                rdata_q   <= rd_data;
                rresp_q   <= rd_resp;
            end else if (axil_req.arvalid && !arready_q && !rvalid_q) begin
                arready_q <= 1'b1;
            end else begin
                arready_q <= 1'b0;
            end
            if (rvalid_q && axil_req.rready) rvalid_q <= 1'b0;
        end
    end

    assign axil_rsp.awready = aw_w_ready;
    assign axil_rsp.wready  = aw_w_ready;
    assign axil_rsp.bvalid  = bvalid_q;
    assign axil_rsp.bresp   = bresp_q;
    assign axil_rsp.arready = arready_q;
    assign axil_rsp.rvalid  = rvalid_q;
    assign axil_rsp.rdata   = rdata_q;
    assign axil_rsp.rresp   = rresp_q;
    assign stored_code      = code_q;

endmodule

/* src/keypad_lock_top.sv */
`timescale 1ns/1ps

module keypad_lock_top (
    input  logic                clk,
    input  logic                reset,
    input  logic [15:0]         onehot,
    input  lock_pkg::axil_req_t axil_req,
    output lock_pkg::axil_rsp_t axil_rsp,
    output lock_pkg::code_t     display,
    output logic                buzzer
);
    import lock_pkg::*;

    key_event_t   key_event;
    code_t        stored_code;
    lock_status_t status;
    tone_e        tone_req;
    logic         unlock;

    keypad_decoder u_decoder (
        .clk       (clk),
        .reset     (reset),
        .onehot    (onehot),
        .key_event (key_event)
    );

    code_checker u_checker (
        .clk         (clk),
        .reset       (reset),
        .key_event   (key_event),
        .stored_code (stored_code),
        .unlock      (unlock),
        .display     (display),
        .status      (status),
        .tone_req    (tone_req)
    );

    buzzer_tone u_buzzer (
        .clk      (clk),
        .reset    (reset),
        .tone_req (tone_req),
        .buzzer   (buzzer)
    );

    lock_regs u_regs (
        .clk         (clk),
        .reset       (reset),
        .axil_req    (axil_req),
        .axil_rsp    (axil_rsp),
        .status      (status),
        .stored_code (stored_code),
        .unlock      (unlock)
    );

endmodule

/* verification/keypad_lock_assertions.sv */
`timescale 1ns/1ps
`include "lock_macros.svh"

module keypad_lock_assertions #(
    parameter bit BUS_CHECKS  = 1'b1,
    parameter bit LOCK_CHECKS = 1'b1
) (
    input logic                   clk,
    input logic                   reset,
    input logic                   bvalid,
    input logic                   bready,
    input logic                   rvalid,
    input logic                   rready,
    input lock_pkg::lock_status_t status,
    input lock_pkg::code_t        display
);
    import lock_pkg::*;

    if (BUS_CHECKS) begin : g_bus
        bvalid_held: assert property (@(posedge clk) disable iff (reset)
            bvalid && !bready |=> bvalid)
            else $error("bvalid dropped before bready");

        rvalid_held: assert property (@(posedge clk) disable iff (reset)
            rvalid && !rready |=> rvalid)
            else $error("rvalid dropped before rready");
    end

    if (LOCK_CHECKS) begin : g_lock
        tries_limit: assert property (@(posedge clk) disable iff (reset)
            status.tries <= `MAX_TRIES)
            else $error("tries above limit: %0d", status.tries);

        locked_display: assert property (@(posedge clk) disable iff (reset)
            status.state == ST_LOCKED |-> display == `DISPLAY_LOCKED)
            else $error("display %h while locked", display);
    end

endmodule

// bus handshake on the register side
bind lock_regs keypad_lock_assertions #(
    .BUS_CHECKS  (1'b1),
    .LOCK_CHECKS (1'b0)
) u_regs_sva (
    .clk     (clk),
    .reset   (reset),
    .bvalid  (axil_rsp.bvalid),
    .bready  (axil_req.bready),
    .rvalid  (axil_rsp.rvalid),
    .rready  (axil_req.rready),
    .status  (status),
    .display ('0)
);

// lock rules only
bind code_checker keypad_lock_assertions #(
    .BUS_CHECKS  (1'b0),
    .LOCK_CHECKS (1'b1)
) u_checker_sva (
    .clk     (clk),
    .reset   (reset),
    .bvalid  (1'b0),
    .bready  (1'b0),
    .rvalid  (1'b0),
    .rready  (1'b0),
    .status  (status),
    .display (display)
);

/* verification/keypad_lock_tb.sv */
`timescale 1ns/1ps
`include "lock_macros.svh"

module keypad_lock_tb;
    import lock_pkg::*;

    localparam int TIMEOUT = 50;    // cycles per handshake wait

    logic        clk;
    logic        reset;
    logic [15:0] onehot;
    axil_req_t   axil_req;
    axil_rsp_t   axil_rsp;
    code_t       display;
    logic        buzzer;

    int  seed = 25;
    int  tests = 0;
    int  errors = 0;
    bit  timeout_hit = 0;
    bit  hist [0:127];    // buzzer after each edge of a press

    keypad_lock_top uut (
        .clk      (clk),
        .reset    (reset),
        .onehot   (onehot),
        .axil_req (axil_req),
        .axil_rsp (axil_rsp),
        .display  (display),
        .buzzer   (buzzer)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic int key_line(input byte c);
        if (c >= "a") return c - "a" + 10;
        return c - "0";
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        tests++;
        if (actual !== expected) begin
            errors++;
            $display("** Error: %s expected %h actual %h", name, expected, actual);
        end else begin
            $display("ok     %s", name);
        end
    endtask

    // which: 0 awready, 1 bvalid, 2 arready, 3 rvalid
    task automatic wait_rsp(input int which, input string what);
        bit seen;
        int n;
        seen = 0;
        n = 0;
        while (!seen && n < TIMEOUT) begin
            @(negedge clk);
            n++;
            case (which)
                0: seen = axil_rsp.awready;
                1: seen = axil_rsp.bvalid;
                2: seen = axil_rsp.arready;
                default: seen = axil_rsp.rvalid;
            endcase
        end
        if (!seen) begin
            $display("timeout while waiting for %s", what);
            timeout_hit = 1;
            errors++;
        end
    endtask

    task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
        int delay;
        delay = {$random(seed)} % 4;    // bready back-pressure
        resp = 2'b11;
        @(posedge clk);
        axil_req.awvalid <= 1'b1;
        axil_req.awaddr  <= addr;
        axil_req.wvalid  <= 1'b1;
        axil_req.wdata   <= data;
        axil_req.wstrb   <= 4'hf;
        wait_rsp(0, "awready");
        @(posedge clk);
        axil_req.awvalid <= 1'b0;
        axil_req.wvalid  <= 1'b0;
        if (timeout_hit) return;
        wait_rsp(1, "bvalid");
        if (timeout_hit) return;
        resp = axil_rsp.bresp;
        repeat (delay) @(posedge clk);
        @(posedge clk);
        axil_req.bready <= 1'b1;
        @(posedge clk);
        axil_req.bready <= 1'b0;
    endtask

    task automatic axi_read(input logic [3:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        int delay;
        delay = {$random(seed)} % 4;    // rready back-pressure
        data = '0;
        resp = 2'b11;
        @(posedge clk);
        axil_req.arvalid <= 1'b1;
        axil_req.araddr  <= addr;
        wait_rsp(2, "arready");
        @(posedge clk);
        axil_req.arvalid <= 1'b0;
        if (timeout_hit) return;
        wait_rsp(3, "rvalid");
        if (timeout_hit) return;
        data = axil_rsp.rdata;
        resp = axil_rsp.rresp;
        repeat (delay) @(posedge clk);
        @(posedge clk);
        axil_req.rready <= 1'b1;
        @(posedge clk);
        axil_req.rready <= 1'b0;
    endtask

    // held 3 cycles, released for the rest, at least 3
    task automatic press_key(input int line, input int watch);
        for (int k = 0; k <= watch; k++) begin
            @(posedge clk);
            if (k == 0) onehot <= 16'd1 << line;
            else if (k == 3) onehot <= '0;
            @(negedge clk);
            hist[k] = buzzer;
        end
    endtask

    // mode 1 click, mode 2 fail tone
    task automatic check_buzzer(input string name, input int line, input int mode);
        int bad_at;
        bad_at = -1;
        tests++;
        if (mode == 1) begin
            press_key(line, `CLICK_LEN + 4);
            if (hist[`CLICK_LEN + 4] != 1'b0) bad_at = `CLICK_LEN + 4;
        end else begin
            press_key(line, `FAIL_LEN);
            for (int k = `FAIL_GAP + 4; k <= `FAIL_LEN; k++) begin
                if (hist[k] != 1'b0 && bad_at < 0) bad_at = k;
            end
        end
        if (hist[3] != 1'b1) begin
            errors++;
            $display("%s: buzzer not high 3 cycles after the key press", name);
        end else if (bad_at >= 0) begin
            errors++;
            $display("%s: buzzer high %0d cycles after the key press", name, bad_at);
        end else begin
            $display("ok     %s", name);
        end
    endtask

    task automatic run_line(input string text);
        string       op;
        string       name;
        string       opnd;
        logic [31:0] exp;
        logic [31:0] arg;
        logic [31:0] rdata;
        logic [1:0]  resp;
        int          n;
        n = $sscanf(text, "%s %s %s %h", op, name, opnd, exp);
        if (n < 4 || op.getc(0) == "#") return;    // comment or blank
        n = $sscanf(opnd, "%h", arg);
        if (op == "key") begin
            for (int i = 0; i < opnd.len(); i++) press_key(key_line(opnd.getc(i)), 6);
        end else if (op == "buzz") begin
            check_buzzer(name, int'(arg), int'(exp));
        end else if (op == "disp") begin
            @(negedge clk);
            check_value(name, exp, {20'd0, display});
        end else if (op == "wr") begin
            axi_write(arg[3:0], exp, resp);
            if (!timeout_hit) check_value(name, 32'd0, {30'd0, resp});
        end else if (op == "rd") begin
            axi_read(arg[3:0], rdata, resp);
            if (!timeout_hit) check_value(name, exp, rdata);
        end else if (op == "rdresp") begin
            axi_read(arg[3:0], rdata, resp);
            if (!timeout_hit) check_value(name, exp, {30'd0, resp});
        end else begin
            errors++;
            $display("unknown operation %s in the vector file", op);
        end
    endtask

    initial begin
        int    fd;
        string line;
        reset    = 1'b1;
        onehot   = '0;
        axil_req = '0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;

        fd = $fopen("verification/keypad_lock_vectors.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open the vector file");
        end else begin
            while (!timeout_hit && $fgets(line, fd) != 0) begin
                run_line(line);
            end
            $fclose(fd);
        end

        $display("tests %0d, passed %0d, failed %0d", tests, tests - errors, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* verification/keypad_lock_vectors.txt */
# op name operand expected, operand and expected in hex
# key operand: keypad lines pressed in order; buzz expected: 1 click, 2 fail
rd      reset_status      4                 0
rd      reset_code        0                 246
disp    reset_blank       0                 fff
buzz    click_2           6                 1
disp    shift_2           0                 ff2
key     press_4_6         b9                0
disp    shift_246         0                 246
key     enter             0                 0
disp    pass_shown        0                 bcc
rd      open_status       4                 1
key     clear_entry       c                 0
disp    entry_blank       0                 fff
key     repeat_1          777               0
disp    three_ones        0                 111
buzz    fail_tone         0                 2
disp    wrong_blank       0                 fff
rd      one_try           4                 4
key     four_wrong        7770777077707770  0
rd      five_tries        4                 14
key     sixth_wrong       7770              0
disp    locked_zeros      0                 000
rd      locked_status     4                 1a
key     locked_digit      7                 0
disp    digit_ignored     0                 000
wr      unlock            8                 1
disp    unlocked_blank    0                 fff
rd      unlocked_status   4                 0
wr      new_code          0                 135
rd      code_readback     0                 135
key     old_code          6b90              0
rd      old_rejected      4                 4
key     new_code_entry    75a0              0
disp    new_pass          0                 bcc
rd      new_open          4                 5
key     clear_all         8                 0
disp    cleared_blank     0                 fff
rd      cleared_status    4                 0
rdresp  unmapped_read     c                 2

/* sim.f */
+incdir+src
src/lock_pkg.sv
src/keypad_decoder.sv
src/code_checker.sv
src/buzzer_tone.sv
src/lock_regs.sv
src/keypad_lock_top.sv
verification/keypad_lock_assertions.sv
verification/keypad_lock_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the keypad lock testbench from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
    --top-module keypad_lock_tb -f sim.f -o keypad_lock_sim \
    && ./obj_dir/keypad_lock_sim | tee /dev/stderr | grep -qx "SIMULATION PASSED" \
    && { echo "run ok"; exit 0; } \
    || { echo "run not ok"; exit 1; }
